/* z88_glue.f */
common/z88_bus_pkg.sv
common/z88_blink_pkg.sv
blink/blink_regs.sv
blink/blink_decode.sv
blink/blink_timer.sv
hw/ps2_keyboard.sv
hw/z88_glue.sv
verif/z88_glue_sva.sv
verif/tb_z88_glue.sv

/* Bender.yml */
package:
  name: z88_glue

sources:
  - files:
      - common/z88_bus_pkg.sv
      - common/z88_blink_pkg.sv
      - blink/blink_regs.sv
      - blink/blink_decode.sv
      - blink/blink_timer.sv
      - hw/ps2_keyboard.sv
      - hw/z88_glue.sv
  - target: simulation
    files:
      - verif/z88_glue_sva.sv
      - verif/tb_z88_glue.sv

/* verif/tb_z88_glue.sv */
`timescale 1ns/1ns

module tb_z88_glue;

  localparam int CLK_PERIOD  = 20;
  localparam int TICK_CYCLES = 20;
  localparam int SEC_CYCLES  = TICK_CYCLES * z88_blink_pkg::TICKS_PER_SEC;
  localparam int PS2_HALF    = 6;  // System clocks per PS/2 clock phase
  // Timer test waits for two seconds events, the rest fits well under 2000 cycles
  localparam int TIMEOUT_CYCLES = 2 * (2 * SEC_CYCLES + 2000);

  logic                  clk;
  logic                  rst_n;
  z88_bus_pkg::cpu_bus_t cpu;
  logic [7:0]            rom_rdata;
  logic [7:0]            ram_rdata;
  logic                  ps2_clk;
  logic                  ps2_dat;
  logic [7:0]            cpu_rdata;
  logic                  int_n;
  z88_bus_pkg::mem_bus_t mem;
  logic [2:0]            se_n;

  int          cycle;
  int          err_count;
  int          check_count;
  logic [31:0] rng_state = 32'd23171;
  logic [7:0]  seg_model [4];
  logic [7:0]  kbd_model [8];  // Expected rows, bit low while held

  z88_glue #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu       (cpu),
    .rom_rdata (rom_rdata),
    .ram_rdata (ram_rdata),
    .ps2_clk   (ps2_clk),
    .ps2_dat   (ps2_dat),
    .cpu_rdata (cpu_rdata),
    .int_n     (int_n),
    .mem       (mem),
    .se_n      (se_n)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycle = 0;
    while (cycle < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle++;
    end
    $display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, err_count - errs_before);
  endtask

  // All bus tasks start and end on a falling edge
  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    cpu       = '0;
    cpu.addr  = addr;
    cpu.wdata = data;
    cpu.iorq  = 1'b1;
    cpu.wr    = 1'b1;
    @(negedge clk);
    cpu = '0;
  endtask

  task automatic io_read(input logic [15:0] addr, input logic [7:0] exp, input string name);
    cpu      = '0;
    cpu.addr = addr;
    cpu.iorq = 1'b1;
    cpu.rd   = 1'b1;
    #(CLK_PERIOD / 4);
    check(name, exp, cpu_rdata);
    @(negedge clk);
    cpu = '0;
  endtask

  task automatic mem_access(input logic [15:0] addr, input logic wr);
    logic [31:0] r;
    logic [7:0]  bank;
    logic [7:0]  exp_rdata;
    logic [2:0]  exp_se;
    logic        rom;
    logic        ram;
    bank = (addr[15:13] == 3'b000) ? 8'h00 : seg_model[addr[15:14]];
    rom  = (bank <= z88_bus_pkg::BANK_ROM_LAST);
    ram  = !rom && (bank <= z88_bus_pkg::BANK_RAM_LAST);
    exp_se = 3'b111;
    if (bank[7:6] != 2'd0) begin
      exp_se[bank[7:6] - 2'd1] = 1'b0;
    end
    r = next_rand();
    rom_rdata = r[7:0];
    ram_rdata = r[7:0] ^ 8'h5A;  // Never equal to the ROM byte
    exp_rdata = rom ? rom_rdata : (ram ? ram_rdata : z88_bus_pkg::FLOAT_DATA);
    cpu       = '0;
    cpu.addr  = addr;
    cpu.wdata = r[15:8];
    cpu.mreq  = 1'b1;
    cpu.rd    = !wr;
    cpu.wr    = wr;
    #(CLK_PERIOD / 4);
    check("mem.addr", {bank[4:0], addr[13:0]}, mem.addr);
    check("mem.wdata", r[15:8], mem.wdata);
    check("mem.rom_ce_n", !rom, mem.rom_ce_n);
    check("mem.ram_ce_n", !ram, mem.ram_ce_n);
    check("mem.oe_n", wr, mem.oe_n);
    check("mem.we_n", !(wr && ram), mem.we_n);
    check("se_n", exp_se, se_n);
    if (!wr) begin
      check("cpu_rdata", exp_rdata, cpu_rdata);
    end
    @(negedge clk);
    cpu = '0;
  endtask

  // Start, 8 data bits LSB first, odd parity, stop
  task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, ~^code ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_dat = bits[i];
      repeat (PS2_HALF) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (PS2_HALF) @(negedge clk);
      ps2_clk = 1'b1;
    end
    ps2_dat = 1'b1;
    repeat (2 * PS2_HALF) @(negedge clk);  // Idle gap covers the receiver latency
  endtask

  task automatic key_event(input int idx, input logic make);
    if (!make) begin
      ps2_send(z88_blink_pkg::PS2_BREAK, 1'b0);
    end
    ps2_send(z88_blink_pkg::KEY_MAP[idx].code, 1'b0);
    kbd_model[z88_blink_pkg::KEY_MAP[idx].row][z88_blink_pkg::KEY_MAP[idx].col] = !make;
  endtask

  task automatic check_kbd(input logic [7:0] mask);
    logic [7:0] exp;
    exp = 8'hFF;
    for (int r = 0; r < 8; r++) begin
      if (!mask[r]) begin
        exp = exp & kbd_model[r];
      end
    end
    io_read({mask, 8'hB2}, exp, "kbd");
  endtask

  task automatic check_kbd_masks();
    logic [31:0] r;
    check_kbd(8'h00);
    check_kbd(8'hDF);
    check_kbd(8'hFE);
    check_kbd(8'hBF);
    check_kbd(8'hFF);
    for (int i = 0; i < 3; i++) begin
      r = next_rand();
      check_kbd(r[7:0]);
    end
  endtask

  // Level on int_n is stable at the falling edge
  task automatic wait_int_low(input int limit, output int at_cycle);
    int n;
    n = 0;
    while (int_n !== 1'b0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (int_n !== 1'b0) begin
      $display("Timer interrupt did not assert within %0d cycles", limit);
      err_count++;
    end
    at_cycle = cycle;
  endtask

  task automatic reset_state();
    int errs0;
    errs0 = err_count;
    #(CLK_PERIOD / 4);
    check("mem.rom_ce_n", 1'b1, mem.rom_ce_n);
    check("mem.ram_ce_n", 1'b1, mem.ram_ce_n);
    check("mem.oe_n", 1'b1, mem.oe_n);
    check("mem.we_n", 1'b1, mem.we_n);
    check("se_n", 3'b111, se_n);
    check("int_n", 1'b1, int_n);
    @(negedge clk);
    for (int s = 0; s < 4; s++) begin
      io_read(16'h00D0 + 16'(s), 8'h00, "sr");
    end
    check_kbd(8'h00);
    report_test("reset_state", errs0);
  endtask

  task automatic bank_translation();
    int          errs0;
    logic [31:0] r;
    logic [15:0] a;
    errs0 = err_count;
    for (int round = 0; round < 6; round++) begin
      for (int s = 0; s < 4; s++) begin
        r = next_rand();
        case (r[9:8])
          2'd0:    seg_model[s] = {3'b000, r[4:0]};  // ROM
          2'd1:    seg_model[s] = {3'b001, r[4:0]};  // RAM
          default: seg_model[s] = r[7:0];
        endcase
        io_write(16'h00D0 + 16'(s), seg_model[s]);
      end
      for (int s = 0; s < 4; s++) begin
        io_read(16'h00D0 + 16'(s), seg_model[s], "sr");
      end
      for (int s = 0; s < 4; s++) begin
        for (int k = 0; k < 2; k++) begin
          r = next_rand();
          a = {2'(s), r[13:0]};
          if (s == 0) begin
            a[13] = k[0];  // Fixed ROM bank 0 window, then the banked upper half
          end
          mem_access(a, k[0]);
        end
      end
    end
    report_test("bank_translation", errs0);
  endtask

  task automatic read_path();
    int errs0;
    errs0 = err_count;
    seg_model[0] = 8'h02;
    seg_model[1] = 8'h10;
    seg_model[2] = 8'h30;
    seg_model[3] = 8'h85;
    for (int s = 0; s < 4; s++) begin
      io_write(16'h00D0 + 16'(s), seg_model[s]);
    end
    mem_access(16'h2345, 1'b0);
    mem_access(16'h4100, 1'b0);
    mem_access(16'h8200, 1'b0);
    mem_access(16'hC300, 1'b0);
    mem_access(16'hC000, 1'b1);  // Slot write, no RAM strobe
    io_read(16'h0070, z88_bus_pkg::FLOAT_DATA, "io_rdata");
    report_test("read_path", errs0);
  endtask

  task automatic keyboard();
    int errs0;
    errs0 = err_count;
    key_event(0, 1'b1);
    key_event(8, 1'b1);
    key_event(13, 1'b1);
    key_event(14, 1'b1);
    check_kbd_masks();
    key_event(0, 1'b0);
    check_kbd_masks();
    ps2_send(z88_blink_pkg::KEY_MAP[6].code, 1'b1);  // Dropped frame
    check_kbd_masks();
    report_test("keyboard", errs0);
  endtask

  task automatic timer_irq();
    int errs0;
    int t0;
    int t1;
    errs0 = err_count;
    io_write(16'h00B5, 8'h01);  // Mask tick only
    io_write(16'h00B4, 8'h03);
    io_write(16'h00B0, 8'h03);
    wait_int_low(TICK_CYCLES + 4, t0);
    io_write(16'h00B4, 8'h01);
    check("int_n", 1'b1, int_n);
    wait_int_low(TICK_CYCLES + 4, t0);
    io_read(16'h00B5, 8'h01, "tsta");
    io_write(16'h00B4, 8'h01);
    check("int_n", 1'b1, int_n);
    wait_int_low(TICK_CYCLES + 4, t1);
    check("tick_period", TICK_CYCLES, t1 - t0);
    io_write(16'h00B5, 8'h02);  // Seconds only
    io_write(16'h00B4, 8'h03);
    wait_int_low(SEC_CYCLES + 2 * TICK_CYCLES, t0);
    io_write(16'h00B4, 8'h02);
    check("int_n", 1'b1, int_n);
    wait_int_low(SEC_CYCLES + 2 * TICK_CYCLES, t1);
    check("sec_period", SEC_CYCLES, t1 - t0);
    io_read(16'h00B5, 8'h03, "tsta");
    io_write(16'h00B0, 8'h02);  // Drop GINT with the flag still pending
    for (int i = 0; i < 2 * TICK_CYCLES; i++) begin
      check("int_n", 1'b1, int_n);
      @(negedge clk);
    end
    report_test("timer_irq", errs0);
  endtask

  initial begin
    err_count   = 0;
    check_count = 0;
    rst_n       = 1'b0;
    cpu         = '0;
    rom_rdata   = 8'h00;
    ram_rdata   = 8'h00;
    ps2_clk     = 1'b1;
    ps2_dat     = 1'b1;
    for (int i = 0; i < 4; i++) begin
      seg_model[i] = 8'h00;
    end
    for (int i = 0; i < 8; i++) begin
      kbd_model[i] = 8'hFF;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_state();
    bank_translation();
    read_path();
    keyboard();
    timer_irq();
    $display("Summary: %0d checks, %0d errors", check_count, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verif/z88_glue_sva.sv */
`timescale 1ns/1ns

module z88_glue_sva (
  input logic                  clk,
  input logic                  rst_n,
  input z88_bus_pkg::cpu_bus_t cpu,
  input z88_bus_pkg::mem_bus_t mem,
  input z88_bus_pkg::mem_sel_e mem_sel,
  input logic [7:0]            int_ctl,
  input logic                  int_n
);

  // Global enable gates the interrupt line
  a_int_gated: assert property (@(posedge clk) disable iff (!rst_n)
    !int_ctl[z88_blink_pkg::INT_GINT] |-> int_n)
    else $error("int_n low while INT_GINT is clear");

  a_ce_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !(!mem.rom_ce_n && !mem.ram_ce_n))
    else $error("ROM and RAM chip selects active together");

  // Writes reach RAM only
  a_we_ram: assert property (@(posedge clk) disable iff (!rst_n)
    !mem.we_n |-> (cpu.wr && mem_sel == z88_bus_pkg::SEL_RAM))
    else $error("we_n low outside a RAM write");

endmodule

bind z88_glue z88_glue_sva i_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .cpu     (cpu),
  .mem     (mem),
  .mem_sel (mem_sel),
  .int_ctl (int_ctl),
  .int_n   (int_n)
);

/* hw/z88_glue.sv */
`timescale 1ns/1ns

module z88_glue #(
  parameter int TICK_CYCLES = 49152  // 5 ms at 9.8304 MHz
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  z88_bus_pkg::cpu_bus_t cpu,
  input  logic [7:0]            rom_rdata,
  input  logic [7:0]            ram_rdata,
  input  logic                  ps2_clk,
  input  logic                  ps2_dat,
  output logic [7:0]            cpu_rdata,
  output logic                  int_n,
  output z88_bus_pkg::mem_bus_t mem,
  output logic [2:0]            se_n
);

  logic [3:0][7:0]            seg_banks;
  logic [7:0]                 int_ctl;
  logic [1:0]                 tmk;
  logic [1:0]                 tack_pulse;
  logic [1:0]                 tsta;
  logic [7:0]                 io_rdata;
  z88_bus_pkg::mem_sel_e      mem_sel;
  z88_blink_pkg::kbd_matrix_t kbd;

  blink_regs i_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu        (cpu),
    .kbd        (kbd),
    .tsta       (tsta),
    .seg_banks  (seg_banks),
    .int_ctl    (int_ctl),
    .tmk        (tmk),
    .tack_pulse (tack_pulse),
    .io_rdata   (io_rdata)
  );

  blink_decode i_decode (
    .cpu       (cpu),
    .seg_banks (seg_banks),
    .mem       (mem),
    .se_n      (se_n),
    .mem_sel   (mem_sel)
  );

  blink_timer #(
    .TICK_CYCLES (TICK_CYCLES)
  ) i_timer (
    .clk        (clk),
    .rst_n      (rst_n),
    .int_ctl    (int_ctl),
    .tmk        (tmk),
    .tack_pulse (tack_pulse),
    .tsta       (tsta),
    .int_n      (int_n)
  );

  ps2_keyboard i_ps2 (
    .clk     (clk),
    .rst_n   (rst_n),
    .ps2_clk (ps2_clk),
    .ps2_dat (ps2_dat),
    .kbd     (kbd)
  );

  // CPU read data
  always_comb begin
    if (cpu.iorq) begin
      cpu_rdata = io_rdata;
    end else if (cpu.mreq) begin
      case (mem_sel)
        z88_bus_pkg::SEL_ROM: cpu_rdata = rom_rdata;
        z88_bus_pkg::SEL_RAM: cpu_rdata = ram_rdata;
        default:              cpu_rdata = z88_bus_pkg::FLOAT_DATA;
      endcase
    end else begin
      cpu_rdata = z88_bus_pkg::FLOAT_DATA;  // Idle bus floats high
    end
  end

endmodule

/* hw/ps2_keyboard.sv */
`timescale 1ns/1ns

module ps2_keyboard (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ps2_clk,
  input  logic                       ps2_dat,
  output z88_blink_pkg::kbd_matrix_t kbd
);

  logic [2:0]  clk_sync;   // Two sync stages and the previous sample
  logic [1:0]  dat_sync;
  logic        clk_fall;
  logic [10:0] frame;      // Start in bit 0, stop in bit 10
  logic [3:0]  bit_cnt;
  logic        frame_vld;
  logic        frame_ok;
  logic [7:0]  code;
  logic        brk_armed;
  logic        key_hit;
  logic [2:0]  key_row;
  logic [2:0]  key_col;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clk_sync <= '1;
      dat_sync <= '1;
    end else begin
      clk_sync <= {clk_sync[1:0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_dat};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];

  always_ff @(posedge clk) begin
    if (clk_fall) begin
      frame <= {dat_sync[1], frame[10:1]};  // LSB first
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      frame_vld <= 1'b0;
    end else begin
      frame_vld <= 1'b0;
      if (clk_fall) begin
        if (bit_cnt == 4'd10) begin
          bit_cnt   <= '0;
          frame_vld <= 1'b1;
        end else if (bit_cnt != 4'd0 || !dat_sync[1]) begin
          bit_cnt <= bit_cnt + 4'd1;  // Wait for a low start bit
        end
      end
    end
  end

  // Start low, stop high, odd parity over data and parity bit
  assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);
  assign code     = frame[8:1];

  always_comb begin
    key_hit = 1'b0;
    key_row = '0;
    key_col = '0;
    for (int i = 0; i < z88_blink_pkg::KEY_COUNT; i++) begin
      if (z88_blink_pkg::KEY_MAP[i].code == code) begin
        key_hit = 1'b1;
        key_row = z88_blink_pkg::KEY_MAP[i].row;
        key_col = z88_blink_pkg::KEY_MAP[i].col;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      kbd       <= '1;
      brk_armed <= 1'b0;
    end else if (frame_vld && frame_ok) begin
      if (code == z88_blink_pkg::PS2_BREAK) begin
        brk_armed <= 1'b1;
      end else begin
        brk_armed <= 1'b0;  // Any other code consumes the prefix
        if (key_hit) begin
          kbd[key_row][key_col] <= brk_armed;  // 0 on make, 1 on release
        end
      end
    end
  end

endmodule

/* blink/blink_timer.sv */
`timescale 1ns/1ns

module blink_timer #(
  parameter int TICK_CYCLES = 49152  // 5 ms at 9.8304 MHz
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] int_ctl,
  input  logic [1:0] tmk,
  input  logic [1:0] tack_pulse,
  output logic [1:0] tsta,
  output logic       int_n
);

  logic [$clog2(TICK_CYCLES)-1:0] presc;
  logic [7:0]                     tick_cnt;  // Ticks within the current second
  logic                           tick;
  logic                           sec;

  assign tick = (presc == ($clog2(TICK_CYCLES))'(TICK_CYCLES - 1));
  assign sec  = tick && (tick_cnt == 8'(z88_blink_pkg::TICKS_PER_SEC - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      presc    <= '0;
      tick_cnt <= '0;
    end else begin
      presc <= tick ? '0 : presc + 1'b1;
      if (sec) begin
        tick_cnt <= '0;
      end else if (tick) begin
        tick_cnt <= tick_cnt + 8'd1;
      end
    end
  end

  // A new event beats an acknowledge in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tsta <= '0;
    end else begin
      tsta[z88_blink_pkg::TSTA_TICK] <= tick |
        (tsta[z88_blink_pkg::TSTA_TICK] & ~tack_pulse[z88_blink_pkg::TSTA_TICK]);
      tsta[z88_blink_pkg::TSTA_SEC] <= sec |
        (tsta[z88_blink_pkg::TSTA_SEC] & ~tack_pulse[z88_blink_pkg::TSTA_SEC]);
    end
  end

  // Level interrupt, held until acknowledged or masked
  assign int_n = !(int_ctl[z88_blink_pkg::INT_GINT] && int_ctl[z88_blink_pkg::INT_TIME] &&
                   |(tsta & tmk));

endmodule

/* blink/blink_decode.sv */
`timescale 1ns/1ns

module blink_decode (
  input  z88_bus_pkg::cpu_bus_t cpu,
  input  logic [3:0][7:0]       seg_banks,
  output z88_bus_pkg::mem_bus_t mem,
  output logic [2:0]            se_n,
  output z88_bus_pkg::mem_sel_e mem_sel
);

  logic [7:0]                       bank;
  logic [z88_bus_pkg::SEG_BITS-1:0] offset;
  logic [21:0]                      bank_addr;
  logic                             is_rom;
  logic                             is_ram;

  always_comb begin
    bank = seg_banks[cpu.addr[15:14]];
    if (cpu.addr[15:13] == 3'b000) begin
      bank = 8'h00;  // Lower 8K of segment 0 is always ROM bank 0
    end
  end

  assign offset    = cpu.addr[z88_bus_pkg::SEG_BITS-1:0];
  assign bank_addr = {bank, offset};

  assign is_rom = (bank <= z88_bus_pkg::BANK_ROM_LAST);
  assign is_ram = !is_rom && (bank <= z88_bus_pkg::BANK_RAM_LAST);

  // Strobes only during a memory cycle
  always_comb begin
    mem.addr     = bank_addr[18:0];
    mem.wdata    = cpu.wdata;
    mem.rom_ce_n = !(cpu.mreq && is_rom);
    mem.ram_ce_n = !(cpu.mreq && is_ram);
    mem.oe_n     = !(cpu.mreq && cpu.rd);
    mem.we_n     = !(cpu.mreq && cpu.wr && is_ram);  // ROM writes go nowhere
  end

  // Card slots by top two bank bits
  assign se_n[0] = !(cpu.mreq && bank[7:6] == 2'd1);
  assign se_n[1] = !(cpu.mreq && bank[7:6] == 2'd2);
  assign se_n[2] = !(cpu.mreq && bank[7:6] == 2'd3);

  always_comb begin
    if (!cpu.mreq) begin
      mem_sel = z88_bus_pkg::SEL_FLOAT;
    end else if (is_rom) begin
      mem_sel = z88_bus_pkg::SEL_ROM;
    end else if (is_ram) begin
      mem_sel = z88_bus_pkg::SEL_RAM;
    end else begin
      mem_sel = z88_bus_pkg::SEL_FLOAT;  // Slots read as floating bus
    end
  end

endmodule

/* blink/blink_regs.sv */
`timescale 1ns/1ns

module blink_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  z88_bus_pkg::cpu_bus_t      cpu,
  input  z88_blink_pkg::kbd_matrix_t kbd,
  input  logic [1:0]                 tsta,
  output logic [3:0][7:0]            seg_banks,
  output logic [7:0]                 int_ctl,
  output logic [1:0]                 tmk,
  output logic [1:0]                 tack_pulse,
  output logic [7:0]                 io_rdata
);

  z88_blink_pkg::io_port_e port;
  logic                    io_wr;
  logic [7:0]              kbd_cols;

  assign port  = z88_blink_pkg::io_port_e'(cpu.addr[7:0]);
  assign io_wr = cpu.iorq & cpu.wr;

  // Acknowledge mask, present for the write cycle only
  assign tack_pulse = (io_wr && port == z88_blink_pkg::TACK_TMK) ? cpu.wdata[1:0] : 2'b00;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seg_banks <= '0;
      int_ctl   <= '0;
      tmk       <= '0;
    end else if (io_wr) begin
      case (port)
        z88_blink_pkg::SR0,
        z88_blink_pkg::SR1,
        z88_blink_pkg::SR2,
        z88_blink_pkg::SR3:     seg_banks[cpu.addr[1:0]] <= cpu.wdata;
        z88_blink_pkg::INT_CTL: int_ctl <= cpu.wdata;
        z88_blink_pkg::TSTA:    tmk <= cpu.wdata[1:0];  // B5 write is TMK
        default: ;
      endcase
    end
  end

  // AND of every row whose select line is low
  always_comb begin
    kbd_cols = 8'hFF;
    for (int r = 0; r < 8; r++) begin
      if (!cpu.addr[8 + r]) begin
        kbd_cols = kbd_cols & kbd[r];
      end
    end
  end

  always_comb begin
    case (port)
      z88_blink_pkg::SR0,
      z88_blink_pkg::SR1,
      z88_blink_pkg::SR2,
      z88_blink_pkg::SR3:  io_rdata = seg_banks[cpu.addr[1:0]];
      z88_blink_pkg::STA:  io_rdata = int_ctl;
      z88_blink_pkg::KBD:  io_rdata = kbd_cols;
      z88_blink_pkg::TSTA: io_rdata = {6'b000000, tsta};
      default:             io_rdata = z88_bus_pkg::FLOAT_DATA;
    endcase
  end

endmodule

/* common/z88_blink_pkg.sv */
package z88_blink_pkg;

  // Blink I/O ports, low address byte
  typedef enum logic [7:0] {
    SR0      = 8'hD0,
    SR1      = 8'hD1,
    SR2      = 8'hD2,
    SR3      = 8'hD3,
    INT_CTL  = 8'hB0,
    STA      = 8'hB1,
    KBD      = 8'hB2,
    TACK_TMK = 8'hB4,  // Timer acknowledge on write
    TSTA     = 8'hB5   // Timer status on read, timer mask on write
  } io_port_e;

  localparam int INT_GINT = 0;
  localparam int INT_TIME = 1;

  localparam int TSTA_TICK = 0;
  localparam int TSTA_SEC  = 1;

  localparam int TICKS_PER_SEC = 200;

  // Set-2 break prefix
  localparam logic [7:0] PS2_BREAK = 8'hF0;

  typedef struct packed {
    logic [7:0] code;
    logic [2:0] row;
    logic [2:0] col;
  } key_entry_t;

  localparam int KEY_COUNT = 16;

  localparam key_entry_t KEY_MAP [KEY_COUNT] = '{
    '{8'h1C, 3'd5, 3'd4},  // A
    '{8'h32, 3'd1, 3'd5},  // B
    '{8'h21, 3'd3, 3'd5},  // C
    '{8'h23, 3'd3, 3'd4},  // D
    '{8'h24, 3'd3, 3'd3},  // E
    '{8'h2B, 3'd2, 3'd4},  // F
    '{8'h34, 3'd1, 3'd4},  // G
    '{8'h33, 3'd0, 3'd4},  // H
    '{8'h16, 3'd5, 3'd2},  // 1
    '{8'h1E, 3'd4, 3'd2},  // 2
    '{8'h26, 3'd3, 3'd2},  // 3
    '{8'h25, 3'd2, 3'd2},  // 4
    '{8'h29, 3'd5, 3'd1},  // Space
    '{8'h5A, 3'd0, 3'd1},  // Enter
    '{8'h12, 3'd6, 3'd6},  // Left shift
    '{8'h66, 3'd0, 3'd0}   // Backspace as delete
  };

  // Row r is read with A(8+r) low, bit clear while key held
  typedef logic [7:0][7:0] kbd_matrix_t;

endpackage

/* common/z88_bus_pkg.sv */
package z88_bus_pkg;

  // One CPU bus cycle, qualifiers active high
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        mreq;
    logic        iorq;
    logic        rd;
    logic        wr;
  } cpu_bus_t;

  // Shared ROM/RAM side of slot 0
  typedef struct packed {
    logic [18:0] addr;      // Low part of the 22-bit bank address
    logic [7:0]  wdata;
    logic        rom_ce_n;
    logic        ram_ce_n;
    logic        oe_n;
    logic        we_n;
  } mem_bus_t;

  // Source of memory read data
  typedef enum logic [1:0] {
    SEL_FLOAT = 2'd0,
    SEL_ROM   = 2'd1,
    SEL_RAM   = 2'd2
  } mem_sel_e;

  localparam logic [7:0] BANK_ROM_LAST = 8'h1F;
  localparam logic [7:0] BANK_RAM_LAST = 8'h3F;  // Slots 1..3 from 0x40, 0x80, 0xC0

  localparam int SEG_BITS = 14;  // 16K segment

  localparam logic [7:0] FLOAT_DATA = 8'hFF;

endpackage
